// File: Bender.yml
package:
  name: simson_game

sources:
  - files:
      - hw/simson_pkg.sv
      - hw/simson_main_if.sv
      - hw/simson_snd_fifo.sv
      - hw/simson_snd_seq.sv
      - hw/simson_game.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/simson_game_tb.sv

// File: dv/simson_model.svh
/*
 * Reference model for the sound path testbench. Tracks the loaded variant,
 * the mono flag and the latch write count, and expands every accepted
 * sound command into the queue of stereo pairs the DUT must produce.
 */
`ifndef SIMSON_MODEL_SVH
`define SIMSON_MODEL_SVH

// Expected pairs in order with left in bits 15..8
// Bit 16 is set on the last pair of a burst
logic [16:0] exp_pairs[$];
logic [1:0]  exp_game = 2'd0;
logic        exp_mono = 1'b0;
int          exp_latch_cnt = 0;

// Sound latch location per variant
function automatic logic [15:0] latch_addr_of(input logic [1:0] game);
    case (game)
        2'd1:    return 16'h1FA0;
        2'd2:    return 16'h5F80;
        default: return 16'h1F80;
    endcase
endfunction

// One pair of a burst with the level in code bits 6..3 scaled by 16
function automatic logic [15:0] pair_for(input logic [7:0] code, input logic mono);
    logic [7:0] amp;
    amp = {code[6:3], 4'h0};
    if (mono) begin
        return {amp, amp};
    end else if (code[7]) begin
        return {8'h00, amp};
    end
    return {amp, 8'h00};
endfunction

// CPU write as seen by the main side
task automatic apply_bus_write(input logic [15:0] addr, input logic [7:0] data);
    logic [15:0] latch;
    latch = latch_addr_of(exp_game);
    if (addr == latch) begin
        exp_latch_cnt++;
        for (int i = 0; i <= data[2:0]; i++) begin
            exp_pairs.push_back({(i == data[2:0]), pair_for(data, exp_mono)});
        end
    end else if (addr == latch + 16'd1) begin
        exp_mono = data[0];
    end
endtask

// Header write where value 3 names no board
task automatic apply_header_write(input logic [1:0] addr, input logic [1:0] data);
    if (addr == 2'd0 && data != 2'd3) begin
        exp_game = data;
    end
endtask

`endif

// File: dv/simson_game_tb.sv
/*
 * Testbench for the game sound path. Loads variants through the header,
 * writes random sound commands on the CPU bus and checks every sample
 * pair against the reference model, with and without output stalls.
 */
`timescale 1ns/1ns

module simson_game_tb;

    localparam int n_var_cmds    = 3;
    localparam int n_burst_cmds  = 24;
    localparam int n_stall_cmds  = 32;
    // Up to 8 pairs per command
    localparam int max_pairs     = 8 * (n_var_cmds + n_burst_cmds + n_stall_cmds);
    localparam int timeout_cycles = 20 * max_pairs + 2000;

    logic                  clk;
    logic                  arst_n;
    logic                  header;
    logic                  prog_we;
    logic [1:0]            prog_addr;
    logic [1:0]            prog_data;
    simson_pkg::cpu_addr_t cpu_addr;
    simson_pkg::cpu_data_t cpu_dout;
    logic                  cpu_we;
    logic                  snd_busy;
    simson_pkg::snd_pair_t snd_pair;
    logic                  snd_valid;
    logic                  snd_ready;
    logic [7:0]            debug_bus;
    simson_pkg::st_t       debug_view;

    int          seed = 3378;
    int          ready_seed = 3378;
    logic [31:0] ready_rnd;
    logic        ready_random = 1'b0;
    int          err_cnt = 0;
    int          cycle_cnt = 0;
    logic        held = 1'b0;
    logic [15:0] held_pair;
    logic [16:0] exp_entry;
    logic        gap_due = 1'b0;
    logic        more_due = 1'b0;

    `include "simson_model.svh"

    simson_game DUT (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .header     ( header     ),
        .prog_we    ( prog_we    ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .cpu_we     ( cpu_we     ),
        .snd_busy   ( snd_busy   ),
        .snd_pair   ( snd_pair   ),
        .snd_valid  ( snd_valid  ),
        .snd_ready  ( snd_ready  ),
        .debug_bus  ( debug_bus  ),
        .debug_view ( debug_view )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string why);
        err_cnt++;
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // One CPU write held off while a command is pending
    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk);
        while (snd_busy) @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        apply_bus_write(addr, data);
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    task automatic prog_write(input logic [1:0] addr, input logic [1:0] data);
        @(negedge clk);
        header    = 1'b1;
        prog_we   = 1'b1;
        prog_addr = addr;
        prog_data = data;
        apply_header_write(addr, data);
        @(negedge clk);
        header  = 1'b0;
        prog_we = 1'b0;
    endtask

    // Low select bits are don't care
    task automatic read_debug(input logic [1:0] mode, output logic [7:0] view);
        logic [31:0] r;
        r = $random(seed);
        @(negedge clk);
        debug_bus = {mode, r[5:0]};
        @(negedge clk);
        view = debug_view;
    endtask

    task automatic drain();
        while (exp_pairs.size() != 0) @(negedge clk);
        @(negedge clk);
        check_val("snd_valid", snd_valid, 32'd0);
        check_val("snd_busy", snd_busy, 32'd0);
    endtask

    // Sample sink that stalls only when enabled
    always @(negedge clk) begin
        ready_rnd = $random(ready_seed);
        snd_ready = ready_random ? ready_rnd[0] : 1'b1;
    end

    // Pair checker with stall stability and burst boundaries
    always @(posedge clk) begin
        if (arst_n) begin
            if (held) begin
                check_val("snd_valid", snd_valid, 32'd1);
                check_val("snd_pair", snd_pair, held_pair);
            end
            // Sequencer sits idle for one cycle after the last pair of a burst
            if (gap_due) begin
                check_val("snd_valid", snd_valid, 32'd0);
            end
            if (more_due) begin
                check_val("snd_valid", snd_valid, 32'd1);
            end
            gap_due  = 1'b0;
            more_due = 1'b0;
            if (snd_valid && snd_ready) begin
                if (exp_pairs.size() == 0) begin
                    fail_now("A sample pair came out with no command left to play");
                end
                exp_entry = exp_pairs.pop_front();
                check_val("snd_pair", snd_pair, exp_entry[15:0]);
                gap_due  = exp_entry[16];
                more_due = !exp_entry[16];
            end
            held      = snd_valid && !snd_ready;
            held_pair = snd_pair;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_cycles) begin
            fail_now($sformatf("Timeout, the test did not finish in %0d cycles",
                               timeout_cycles));
        end
    end

    initial begin : main
        logic [7:0]  view;
        logic [31:0] r;
        arst_n    = 1'b0;
        header    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = 2'd0;
        prog_data = 2'd0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_we    = 1'b0;
        snd_ready = 1'b1;
        debug_bus = 8'd0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Reset state
        check_val("snd_valid", snd_valid, 32'd0);
        check_val("snd_busy", snd_busy, 32'd0);
        check_val("debug_view", debug_view, 32'd0);
        read_debug(2'd3, view);
        check_val("debug_view", view, {6'd0, exp_game});

        // Each variant only answers on its own latch address
        for (int v = 0; v < 3; v++) begin
            prog_write(2'd0, 2'(v));
            read_debug(2'd3, view);
            check_val("debug_view", view, {6'd0, exp_game});
            for (int a = 0; a < 3; a++) begin
                r = $random(seed);
                cpu_write(latch_addr_of(2'(a)), r[7:0]);
            end
            drain();
        end
        prog_write(2'd0, 2'd3);
        prog_write(2'd1, 2'd0);
        read_debug(2'd3, view);
        check_val("debug_view", view, {6'd0, exp_game});

        // Random codes with mono set through the register
        for (int i = 0; i < n_burst_cmds; i++) begin
            r = $random(seed);
            cpu_write(latch_addr_of(exp_game) + 16'd1, r[15:8]);
            cpu_write(latch_addr_of(exp_game), r[7:0]);
        end
        drain();

        // Output stalls back up into the FIFO
        ready_random = 1'b1;
        for (int i = 0; i < n_stall_cmds; i++) begin
            r = $random(seed);
            if (r[16]) begin
                cpu_write(latch_addr_of(exp_game) + 16'd1, r[15:8]);
            end
            cpu_write(latch_addr_of(exp_game), r[7:0]);
        end
        drain();
        ready_random = 1'b0;

        // Status after the stream has drained
        read_debug(2'd0, view);
        check_val("debug_view", view, exp_latch_cnt % 256);
        read_debug(2'd1, view);
        check_val("debug_view", view, 32'd0);
        read_debug(2'd2, view);
        check_val("debug_view", view, 32'd0);

        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hw/simson_game.sv
/*
 * Game top level for the sound command path. Latches the loaded variant
 * from the ROM-download header, chains the main interface, command FIFO
 * and sequencer, and registers a debug status byte picked by debug_bus.
 */
`timescale 1ns/1ns

module simson_game (
    input  logic                  clk,
    input  logic                  arst_n,

    // ROM download
    input  logic                  header,
    input  logic                  prog_we,
    input  logic [1:0]            prog_addr,
    input  logic [1:0]            prog_data,

    // Main CPU bus
    input  simson_pkg::cpu_addr_t cpu_addr,
    input  simson_pkg::cpu_data_t cpu_dout,
    input  logic                  cpu_we,

    output logic                  snd_busy,

    // Sound output
    output simson_pkg::snd_pair_t snd_pair,
    output logic                  snd_valid,
    input  logic                  snd_ready,

    // Debug
    input  logic [7:0]            debug_bus,
    output simson_pkg::st_t       debug_view
);

    simson_pkg::game_t     game;
    simson_pkg::snd_cmd_t  cmd;
    simson_pkg::snd_cmd_t  fifo_cmd;
    simson_pkg::fifo_cnt_t fifo_fill;
    simson_pkg::st_t       st_main;
    simson_pkg::st_t       st_snd;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  fifo_valid;
    logic                  fifo_ready;

    // Variant from the header where value 3 is not a board
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            game <= simson_pkg::game_simson;
        end else if (header && prog_we && prog_addr == 2'd0 && prog_data != 2'd3) begin
            game <= simson_pkg::game_t'(prog_data);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            debug_view <= '0;
        end else begin
            case (debug_bus[7:6])
                2'd0: debug_view <= st_main;
                2'd1: debug_view <= simson_pkg::st_t'(fifo_fill);
                2'd2: debug_view <= st_snd;
                default: debug_view <= simson_pkg::st_t'(game);
            endcase
        end
    end

    simson_main_if u_main (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .game      ( game       ),
        .cpu_addr  ( cpu_addr   ),
        .cpu_dout  ( cpu_dout   ),
        .cpu_we    ( cpu_we     ),
        .cmd       ( cmd        ),
        .cmd_valid ( cmd_valid  ),
        .cmd_ready ( cmd_ready  ),
        .snd_busy  ( snd_busy   ),
        .st_dout   ( st_main    )
    );

    simson_snd_fifo u_fifo (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .in_cmd    ( cmd        ),
        .in_valid  ( cmd_valid  ),
        .in_ready  ( cmd_ready  ),
        .out_cmd   ( fifo_cmd   ),
        .out_valid ( fifo_valid ),
        .out_ready ( fifo_ready ),
        .fill      ( fifo_fill  )
    );

    simson_snd_seq u_seq (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .cmd       ( fifo_cmd   ),
        .cmd_valid ( fifo_valid ),
        .cmd_ready ( fifo_ready ),
        .snd_pair  ( snd_pair   ),
        .snd_valid ( snd_valid  ),
        .snd_ready ( snd_ready  ),
        .st_dout   ( st_snd     )
    );

endmodule

// File: hw/simson_main_if.sv
/*
 * Main CPU side of the sound path. Decodes bus writes to the sound latch
 * and the mono register of the loaded variant, and holds one command
 * until the FIFO takes it. snd_busy tells the CPU to hold off.
 */
`timescale 1ns/1ns

module simson_main_if (
    input  logic                  clk,
    input  logic                  arst_n,

    input  simson_pkg::game_t     game,

    // CPU bus with one write per cycle while cpu_we is high
    input  simson_pkg::cpu_addr_t cpu_addr,
    input  simson_pkg::cpu_data_t cpu_dout,
    input  logic                  cpu_we,

    // Towards the command FIFO
    output simson_pkg::snd_cmd_t  cmd,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,

    output logic                  snd_busy,

    // Debug
    output simson_pkg::st_t       st_dout
);

    simson_pkg::cpu_addr_t latch_addr;
    simson_pkg::cpu_addr_t mono_addr;
    simson_pkg::st_t       latch_cnt;
    logic                  latch_wr;
    logic                  latch_take;
    logic                  mono_wr;
    logic                  mono;

    // Latch location moves between the three boards
    always_comb begin
        case (game)
            simson_pkg::game_paroda:   latch_addr = simson_pkg::latch_addr_paroda;
            simson_pkg::game_vendetta: latch_addr = simson_pkg::latch_addr_vendetta;
            default:                   latch_addr = simson_pkg::latch_addr_simson;
        endcase
    end

    assign mono_addr = simson_pkg::cpu_addr_t'(latch_addr + 16'd1);

    assign latch_wr   = cpu_we && (cpu_addr == latch_addr);
    assign mono_wr    = cpu_we && (cpu_addr == mono_addr);
    // A write on top of a pending command is dropped
    assign latch_take = latch_wr && !cmd_valid;

    assign snd_busy = cmd_valid;
    assign st_dout  = latch_cnt;

    // Control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
            mono      <= 1'b0;
            latch_cnt <= '0;
        end else begin
            // Only bit 0 of the mono register exists
            if (mono_wr) begin
                mono <= cpu_dout[0];
            end
            if (latch_take) begin
                cmd_valid <= 1'b1;
                latch_cnt <= latch_cnt + 8'd1;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    // Pending command with mono sampled at the latch write
    always_ff @(posedge clk) begin
        if (latch_take) begin
            cmd.code <= cpu_dout;
            cmd.mono <= mono;
        end
    end

    // CPU software has to poll snd_busy before writing the latch
    a_no_latch_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        latch_wr |-> !cmd_valid
    ) else $error("sound latch written while a command is pending");

endmodule

// File: hw/simson_pkg.sv
/*
 * Shared types and constants for the sound command path of the game core.
 * Holds the variant encoding, the CPU address map of the sound latch,
 * the sound command layout and the FIFO sizing. Referenced by scoped names.
 */
package simson_pkg;

    // Game variant as written in the ROM-download header
    typedef enum logic [1:0] {
        game_simson   = 2'd0,
        game_paroda   = 2'd1,
        game_vendetta = 2'd2
    } game_t;

    // Main CPU bus
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // Sound command code with side in bit 7, level in 6..3 and length-1 in 2..0
    typedef logic [7:0]  snd_code_t;
    typedef logic [3:0]  level_t;
    typedef logic [2:0]  burst_len_t;

    localparam int code_side_bit  = 7;
    localparam int code_level_msb = 6;
    localparam int code_level_lsb = 3;
    localparam int code_len_msb   = 2;

    // One channel sample
    typedef logic [7:0]  sample_t;

    // Sample = level << level_shift
    localparam int level_shift = 4;

    // Count of pairs left in a burst up to 8
    localparam int burst_cnt_w = 4;
    typedef logic [burst_cnt_w-1:0] burst_cnt_t;

    // Debug status byte
    typedef logic [7:0]  st_t;

    typedef struct packed {
        snd_code_t code;
        logic      mono;
    } snd_cmd_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } snd_pair_t;

    // Sound latch per variant with the mono register at latch + 1
    localparam cpu_addr_t latch_addr_simson   = 16'h1F80;
    localparam cpu_addr_t latch_addr_paroda   = 16'h1FA0;
    localparam cpu_addr_t latch_addr_vendetta = 16'h5F80;

    // Command FIFO between main and sound sides
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    // Fill count must reach fifo_depth itself
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
    typedef logic [fifo_cnt_w-1:0] fifo_cnt_t;

endpackage

// File: hw/simson_snd_fifo.sv
/*
 * Circular buffer of sound commands between the main and sound sides.
 * Valid/ready on both ports, push and pop allowed in the same cycle.
 */
`timescale 1ns/1ns

module simson_snd_fifo (
    input  logic                  clk,
    input  logic                  arst_n,

    // Write side
    input  simson_pkg::snd_cmd_t  in_cmd,
    input  logic                  in_valid,
    output logic                  in_ready,

    // Read side
    output simson_pkg::snd_cmd_t  out_cmd,
    output logic                  out_valid,
    input  logic                  out_ready,

    output simson_pkg::fifo_cnt_t fill
);

    simson_pkg::snd_cmd_t  mem [simson_pkg::fifo_depth];
    simson_pkg::fifo_ptr_t wr_ptr;
    simson_pkg::fifo_ptr_t rd_ptr;
    logic                  push;
    logic                  pop;

    assign in_ready  = fill != simson_pkg::fifo_cnt_t'(simson_pkg::fifo_depth);
    assign out_valid = fill != '0;
    assign out_cmd   = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_cmd;
        end
    end

    a_fill_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        fill <= simson_pkg::fifo_cnt_t'(simson_pkg::fifo_depth)
    ) else $error("command FIFO fill count above depth");

    // Full and not drained means nothing got in
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        !in_ready && !pop |=> !in_ready && $stable(wr_ptr)
    ) else $error("command pushed into a full FIFO");

endmodule

// File: hw/simson_snd_seq.sv
/*
 * Sound sequencer. Takes one command at a time and plays it out as a
 * burst of identical stereo pairs on a valid/ready output.
 */
`timescale 1ns/1ns

module simson_snd_seq (
    input  logic                   clk,
    input  logic                   arst_n,

    // Command input from the FIFO
    input  simson_pkg::snd_cmd_t   cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,

    // Sample pairs out
    output simson_pkg::snd_pair_t  snd_pair,
    output logic                   snd_valid,
    input  logic                   snd_ready,

    // Debug
    output simson_pkg::st_t        st_dout
);

    typedef enum logic {
        st_idle,
        st_play
    } state_t;

    state_t                 state;
    simson_pkg::burst_cnt_t remain;
    simson_pkg::snd_pair_t  pair_q;
    simson_pkg::snd_pair_t  next_pair;
    simson_pkg::level_t     level;
    simson_pkg::burst_len_t len;
    simson_pkg::sample_t    amp;
    logic                   take;
    logic                   give;
    logic                   last;

    assign cmd_ready = state == st_idle;
    assign snd_valid = state == st_play;
    assign snd_pair  = pair_q;

    assign take = cmd_valid && cmd_ready;
    assign give = snd_valid && snd_ready;
    assign last = remain == simson_pkg::burst_cnt_t'(1);

    // Decode the command code fields
    assign level = cmd.code[simson_pkg::code_level_msb:simson_pkg::code_level_lsb];
    assign len   = cmd.code[simson_pkg::code_len_msb:0];
    assign amp   = simson_pkg::sample_t'(level) << simson_pkg::level_shift;

    always_comb begin
        next_pair = '0;
        if (cmd.mono) begin
            next_pair.left  = amp;
            next_pair.right = amp;
        end else if (cmd.code[simson_pkg::code_side_bit]) begin
            next_pair.right = amp;
        end else begin
            next_pair.left  = amp;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_idle;
            remain <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (take) begin
                        state  <= st_play;
                        remain <= simson_pkg::burst_cnt_t'(len) + 1'b1;
                    end
                end
                st_play: begin
                    if (give) begin
                        remain <= remain - 1'b1;
                        // back to idle after the last pair
                        if (last) state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // The pair is fixed for the whole burst
    always_ff @(posedge clk) begin
        if (take) begin
            pair_q <= next_pair;
        end
    end

    assign st_dout = {snd_valid, {(7 - simson_pkg::burst_cnt_w){1'b0}}, remain};

    a_pair_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        snd_valid && !snd_ready |=> snd_valid && $stable(snd_pair)
    ) else $error("sample pair changed while stalled");

endmodule

// File: simson_game.f
+incdir+dv
hw/simson_pkg.sv
hw/simson_main_if.sv
hw/simson_snd_fifo.sv
hw/simson_snd_seq.sv
hw/simson_game.sv
dv/simson_game_tb.sv
